//--- hdl/rv32i_cfg.svh
`ifndef RV32I_CFG_SVH
`define RV32I_CFG_SVH

// ########################################
// core sizing
// ########################################

// data, address and instruction width
`define RV32I_XLEN 32

// architectural register count, x0 included
`define RV32I_NUM_REGS 32

// register index width
`define RV32I_REG_BITS 5

`endif

//--- hdl/rv32i_types.sv
`default_nettype none

`include "rv32i_cfg.svh"

package rv32i_types;

    typedef logic [`RV32I_XLEN-1:0] rv32i_word;
    typedef logic [`RV32I_REG_BITS-1:0] rv32i_reg;

    // ########################################
    // encodings
    // ########################################

    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv32i_opcode;

    // {funct7 bit 5, funct3} of the matching OP instruction
    typedef enum logic [3:0] {
        alu_add = 4'b0000,
        alu_sll = 4'b0001,
        alu_xor = 4'b0100,
        alu_srl = 4'b0101,
        alu_or  = 4'b0110,
        alu_and = 4'b0111,
        alu_sub = 4'b1000,
        alu_sra = 4'b1101
    } alu_ops;

    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct3;

    typedef enum logic {a_rs1, a_pc} alumux1_sel_t;

    typedef enum logic [2:0] {
        b_i_imm = 3'd0,
        b_u_imm = 3'd1,
        b_b_imm = 3'd2,
        b_s_imm = 3'd3,
        b_j_imm = 3'd4,
        b_rs2   = 3'd5
    } alumux2_sel_t;

    typedef enum logic {cmp_rs2, cmp_i_imm} cmpmux_sel_t;

    typedef enum logic [1:0] {wb_alu, wb_br_en, wb_u_imm, wb_pc_plus4} regfilemux_sel_t;

    typedef struct packed {
        rv32i_opcode     opcode;
        alu_ops          aluop;
        branch_funct3    cmpop;
        alumux1_sel_t    alumux1_sel;
        alumux2_sel_t    alumux2_sel;
        cmpmux_sel_t     cmpmux_sel;
        regfilemux_sel_t regfilemux_sel;
        logic            branch;
        logic            jump;
        logic            load_regfile;
    } rv32i_control_word;

endpackage

`default_nettype wire

//--- hdl/stage_if.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv32i_cfg.svh"

interface id_ex_if;
    import rv32i_types::*;

    logic              valid;
    rv32i_word         pc;
    rv32i_word         instr;
    rv32i_control_word ctrl;
    rv32i_word         rs1_data;
    rv32i_word         rs2_data;
    rv32i_reg          rd;
    rv32i_word         i_imm;
    rv32i_word         s_imm;
    rv32i_word         b_imm;
    rv32i_word         u_imm;
    rv32i_word         j_imm;

    modport src (output valid, pc, instr, ctrl, rs1_data, rs2_data, rd,
                 i_imm, s_imm, b_imm, u_imm, j_imm);
    modport dst (input valid, pc, instr, ctrl, rs1_data, rs2_data, rd,
                 i_imm, s_imm, b_imm, u_imm, j_imm);
endinterface

interface ex_wb_if;
    import rv32i_types::*;

    logic              valid;
    rv32i_word         pc;
    rv32i_word         pc_plus4;
    rv32i_control_word ctrl;
    rv32i_reg          rd;
    rv32i_word         alu_out;
    logic              br_en;
    rv32i_word         u_imm;

    modport src (output valid, pc, pc_plus4, ctrl, rd, alu_out, br_en, u_imm);
    modport dst (input valid, pc, pc_plus4, ctrl, rd, alu_out, br_en, u_imm);
endinterface

`default_nettype wire

//--- hdl/regfile.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv32i_cfg.svh"

module regfile (
    input  wire logic                 clk,
    input  wire logic                 rst_n_i,
    input  wire logic                 we_i,
    input  rv32i_types::rv32i_reg     waddr_i,
    input  rv32i_types::rv32i_word    wdata_i,
    input  rv32i_types::rv32i_reg     raddr1_i,
    input  rv32i_types::rv32i_reg     raddr2_i,
    output rv32i_types::rv32i_word    rdata1_o,
    output rv32i_types::rv32i_word    rdata2_o
);
    import rv32i_types::*;

    rv32i_word regs [`RV32I_NUM_REGS];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `RV32I_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i; // x0 never written
        end
    end

    // a write landing this cycle is seen by the reader in decode
    always_comb begin
        if (we_i && waddr_i != '0 && waddr_i == raddr1_i) rdata1_o = wdata_i;
        else                                              rdata1_o = regs[raddr1_i];

        if (we_i && waddr_i != '0 && waddr_i == raddr2_i) rdata2_o = wdata_i;
        else                                              rdata2_o = regs[raddr2_i];
    end

    a_x0_reads_zero: assert property (@(posedge clk) disable iff (!rst_n_i)
        raddr1_i == '0 |-> rdata1_o == '0);

endmodule

`default_nettype wire

//--- hdl/alu.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv32i_cfg.svh"

module alu (
    input  rv32i_types::alu_ops    aluop_i,
    input  rv32i_types::rv32i_word a_i,
    input  rv32i_types::rv32i_word b_i,
    output rv32i_types::rv32i_word f_o
);
    import rv32i_types::*;

    logic [4:0] shamt;

    assign shamt = b_i[4:0]; // only the low five bits shift

    always_comb begin
        case (aluop_i)
            alu_add: f_o = a_i + b_i;
            alu_sub: f_o = a_i - b_i;
            alu_sll: f_o = a_i << shamt;
            alu_srl: f_o = a_i >> shamt;
            alu_sra: f_o = rv32i_word'($signed(a_i) >>> shamt);
            alu_xor: f_o = a_i ^ b_i;
            alu_or:  f_o = a_i | b_i;
            alu_and: f_o = a_i & b_i;
            default: f_o = a_i + b_i;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/id_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv32i_cfg.svh"

module id_stage (
    input  wire logic              clk,
    input  wire logic              rst_n_i,
    input  wire logic              instr_valid_i,
    input  rv32i_types::rv32i_word instr_i,
    input  rv32i_types::rv32i_word pc_i,
    output rv32i_types::rv32i_reg  rf_raddr1_o,
    output rv32i_types::rv32i_reg  rf_raddr2_o,
    input  rv32i_types::rv32i_word rf_rdata1_i,
    input  rv32i_types::rv32i_word rf_rdata2_i,
    id_ex_if.src                   id_ex
);
    import rv32i_types::*;

    rv32i_opcode       opcode;
    logic [2:0]        funct3;
    logic              funct7_b5;
    rv32i_control_word ctrl;
    logic              known_op;
    rv32i_word         i_imm, s_imm, b_imm, u_imm, j_imm;

    assign opcode      = rv32i_opcode'(instr_i[6:0]);
    assign funct3      = instr_i[14:12];
    assign funct7_b5   = instr_i[30];
    assign rf_raddr1_o = instr_i[19:15];
    assign rf_raddr2_o = instr_i[24:20];

    // ########################################
    // immediates
    // ########################################

    assign i_imm = {{21{instr_i[31]}}, instr_i[30:20]};
    assign s_imm = {{21{instr_i[31]}}, instr_i[30:25], instr_i[11:7]};
    assign b_imm = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
    assign u_imm = {instr_i[31:12], 12'h000};
    assign j_imm = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

    // ########################################
    // control word
    // ########################################

    always_comb begin
        ctrl                = '0;
        ctrl.opcode         = opcode;
        ctrl.aluop          = alu_add;
        ctrl.cmpop          = branch_funct3'(funct3);
        ctrl.alumux1_sel    = a_rs1;
        ctrl.alumux2_sel    = b_i_imm;
        ctrl.cmpmux_sel     = cmp_rs2;
        ctrl.regfilemux_sel = wb_alu;
        known_op            = 1'b1;

        case (opcode)
            op_lui: begin
                ctrl.load_regfile   = 1'b1;
                ctrl.regfilemux_sel = wb_u_imm;
            end
            op_auipc: begin
                ctrl.load_regfile = 1'b1;
                ctrl.alumux1_sel  = a_pc;
                ctrl.alumux2_sel  = b_u_imm;
            end
            op_jal: begin
                ctrl.jump           = 1'b1;
                ctrl.load_regfile   = 1'b1;
                ctrl.alumux1_sel    = a_pc;
                ctrl.alumux2_sel    = b_j_imm;
                ctrl.regfilemux_sel = wb_pc_plus4;
            end
            op_jalr: begin
                ctrl.jump           = 1'b1;
                ctrl.load_regfile   = 1'b1;
                ctrl.regfilemux_sel = wb_pc_plus4; // target is rs1 + i_imm
            end
            op_br: begin
                ctrl.branch      = 1'b1;
                ctrl.alumux1_sel = a_pc;
                ctrl.alumux2_sel = b_b_imm;
                known_op         = !(funct3 inside {3'b010, 3'b011});
            end
            op_imm, op_reg: begin
                ctrl.load_regfile = 1'b1;
                ctrl.alumux2_sel  = (opcode == op_reg) ? b_rs2 : b_i_imm;
                ctrl.cmpmux_sel   = (opcode == op_reg) ? cmp_rs2 : cmp_i_imm;
                case (funct3)
                    3'b000: ctrl.aluop = (opcode == op_reg && funct7_b5) ? alu_sub : alu_add;
                    3'b001: ctrl.aluop = alu_sll;
                    3'b010: begin
                        ctrl.cmpop          = blt; // slt goes through the comparator
                        ctrl.regfilemux_sel = wb_br_en;
                    end
                    3'b011: begin
                        ctrl.cmpop          = bltu;
                        ctrl.regfilemux_sel = wb_br_en;
                    end
                    3'b100: ctrl.aluop = alu_xor;
                    3'b101: ctrl.aluop = funct7_b5 ? alu_sra : alu_srl;
                    3'b110: ctrl.aluop = alu_or;
                    default: ctrl.aluop = alu_and;
                endcase
            end
            default: known_op = 1'b0; // decoded as a bubble
        endcase
    end

    // ########################################
    // id/ex register
    // ########################################

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) id_ex.valid <= 1'b0;
        else          id_ex.valid <= instr_valid_i && known_op;
    end

    always_ff @(posedge clk) begin
        if (instr_valid_i) begin
            id_ex.pc       <= pc_i;
            id_ex.instr    <= instr_i;
            id_ex.ctrl     <= ctrl;
            id_ex.rs1_data <= rf_rdata1_i;
            id_ex.rs2_data <= rf_rdata2_i;
            id_ex.rd       <= instr_i[11:7];
            id_ex.i_imm    <= i_imm;
            id_ex.s_imm    <= s_imm;
            id_ex.b_imm    <= b_imm;
            id_ex.u_imm    <= u_imm;
            id_ex.j_imm    <= j_imm;
        end
    end

endmodule

`default_nettype wire

//--- hdl/ex_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv32i_cfg.svh"

module ex_stage (
    input  wire logic              clk,
    input  wire logic              rst_n_i,
    id_ex_if.dst                   id_ex,
    ex_wb_if.src                   ex_wb,
    output logic                   redirect_o,
    output rv32i_types::rv32i_word redirect_pc_o
);
    import rv32i_types::*;

    rv32i_word alu_a;
    rv32i_word alu_b;
    rv32i_word alu_out;
    rv32i_word cmp_b;
    logic      br_en;
    rv32i_word pc_plus4;
    rv32i_word target;
    logic      taken;

    // ########################################
    // operand selection
    // ########################################

    always_comb begin
        alu_a = (id_ex.ctrl.alumux1_sel == a_pc) ? id_ex.pc : id_ex.rs1_data;

        case (id_ex.ctrl.alumux2_sel)
            b_i_imm: alu_b = id_ex.i_imm;
            b_u_imm: alu_b = id_ex.u_imm;
            b_b_imm: alu_b = id_ex.b_imm;
            b_s_imm: alu_b = id_ex.s_imm;
            b_j_imm: alu_b = id_ex.j_imm;
            default: alu_b = id_ex.rs2_data;
        endcase
    end

    alu u_alu (
        .aluop_i (id_ex.ctrl.aluop),
        .a_i     (alu_a),
        .b_i     (alu_b),
        .f_o     (alu_out)
    );

    // comparator also serves slt and sltu
    always_comb begin
        cmp_b = (id_ex.ctrl.cmpmux_sel == cmp_i_imm) ? id_ex.i_imm : id_ex.rs2_data;

        case (id_ex.ctrl.cmpop)
            beq:     br_en = id_ex.rs1_data == cmp_b;
            bne:     br_en = id_ex.rs1_data != cmp_b;
            blt:     br_en = $signed(id_ex.rs1_data) < $signed(cmp_b);
            bge:     br_en = $signed(id_ex.rs1_data) >= $signed(cmp_b);
            bltu:    br_en = id_ex.rs1_data < cmp_b;
            default: br_en = id_ex.rs1_data >= cmp_b;
        endcase
    end

    assign pc_plus4 = id_ex.pc + rv32i_word'(4);
    assign target   = (id_ex.ctrl.opcode == op_jalr) ? (alu_out & ~rv32i_word'(1)) : alu_out;
    assign taken    = id_ex.ctrl.jump || (id_ex.ctrl.branch && br_en);

    // ########################################
    // ex/wb register
    // ########################################

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_wb.valid <= 1'b0;
            redirect_o  <= 1'b0;
        end else begin
            ex_wb.valid <= id_ex.valid;
            redirect_o  <= id_ex.valid && taken; // one pulse per taken transfer
        end
    end

    always_ff @(posedge clk) begin
        ex_wb.pc       <= id_ex.pc;
        ex_wb.pc_plus4 <= pc_plus4;
        ex_wb.ctrl     <= id_ex.ctrl;
        ex_wb.rd       <= id_ex.rd;
        ex_wb.alu_out  <= alu_out;
        ex_wb.br_en    <= br_en;
        ex_wb.u_imm    <= id_ex.u_imm;
        redirect_pc_o  <= target;
    end

    a_alumux2_legal: assert property (@(posedge clk) disable iff (!rst_n_i)
        id_ex.valid |-> id_ex.ctrl.alumux2_sel inside
            {b_i_imm, b_u_imm, b_b_imm, b_s_imm, b_j_imm, b_rs2});

endmodule

`default_nettype wire

//--- hdl/wb_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv32i_cfg.svh"

module wb_stage (
    ex_wb_if.dst                   ex_wb,
    output logic                   rf_we_o,
    output rv32i_types::rv32i_reg  rf_waddr_o,
    output rv32i_types::rv32i_word rf_wdata_o,
    output logic                   wb_valid_o,
    output rv32i_types::rv32i_reg  wb_rd_o,
    output rv32i_types::rv32i_word wb_data_o,
    output rv32i_types::rv32i_word wb_pc_o
);
    import rv32i_types::*;

    rv32i_word wb_data;

    always_comb begin
        case (ex_wb.ctrl.regfilemux_sel)
            wb_alu:   wb_data = ex_wb.alu_out;
            wb_br_en: wb_data = rv32i_word'(ex_wb.br_en); // zero extended
            wb_u_imm: wb_data = ex_wb.u_imm;
            default:  wb_data = ex_wb.pc_plus4;
        endcase
    end

    assign rf_we_o    = ex_wb.valid && ex_wb.ctrl.load_regfile && (ex_wb.rd != '0);
    assign rf_waddr_o = ex_wb.rd;
    assign rf_wdata_o = wb_data;

    // report mirrors the register write
    assign wb_valid_o = rf_we_o;
    assign wb_rd_o    = ex_wb.rd;
    assign wb_data_o  = wb_data;
    assign wb_pc_o    = ex_wb.pc;

endmodule

`default_nettype wire

//--- hdl/rv32i_ex_core.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv32i_cfg.svh"

module rv32i_ex_core (
    input  wire logic              clk,
    input  wire logic              rst_n_i,
    input  wire logic              instr_valid_i,
    input  rv32i_types::rv32i_word instr_i,
    input  rv32i_types::rv32i_word pc_i,
    output logic                   wb_valid_o,
    output rv32i_types::rv32i_reg  wb_rd_o,
    output rv32i_types::rv32i_word wb_data_o,
    output rv32i_types::rv32i_word wb_pc_o,
    output logic                   redirect_o,
    output rv32i_types::rv32i_word redirect_pc_o
);
    import rv32i_types::*;

    rv32i_reg  rf_raddr1;
    rv32i_reg  rf_raddr2;
    rv32i_word rf_rdata1;
    rv32i_word rf_rdata2;
    logic      rf_we;
    rv32i_reg  rf_waddr;
    rv32i_word rf_wdata;

    id_ex_if id_ex ();
    ex_wb_if ex_wb ();

    regfile u_regfile (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .we_i     (rf_we),
        .waddr_i  (rf_waddr),
        .wdata_i  (rf_wdata),
        .raddr1_i (rf_raddr1),
        .raddr2_i (rf_raddr2),
        .rdata1_o (rf_rdata1),
        .rdata2_o (rf_rdata2)
    );

    id_stage u_id_stage (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .rf_raddr1_o   (rf_raddr1),
        .rf_raddr2_o   (rf_raddr2),
        .rf_rdata1_i   (rf_rdata1),
        .rf_rdata2_i   (rf_rdata2),
        .id_ex         (id_ex.src)
    );

    ex_stage u_ex_stage (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .id_ex         (id_ex.dst),
        .ex_wb         (ex_wb.src),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o)
    );

    wb_stage u_wb_stage (
        .ex_wb      (ex_wb.dst),
        .rf_we_o    (rf_we),
        .rf_waddr_o (rf_waddr),
        .rf_wdata_o (rf_wdata),
        .wb_valid_o (wb_valid_o),
        .wb_rd_o    (wb_rd_o),
        .wb_data_o  (wb_data_o),
        .wb_pc_o    (wb_pc_o)
    );

endmodule

`default_nettype wire

//--- verif/tb_checker.sv
`timescale 1ns/1ns
`default_nettype none

module tb_checker (
    input  wire logic              clk,
    input  wire logic              rst_n_i,
    input  wire logic              wb_valid_i,
    input  rv32i_types::rv32i_reg  wb_rd_i,
    input  rv32i_types::rv32i_word wb_data_i,
    input  rv32i_types::rv32i_word wb_pc_i,
    input  wire logic              redirect_i,
    input  rv32i_types::rv32i_word redirect_pc_i,
    output int                     pending_o,
    output int                     mismatch_o,
    output int                     other_errs_o
);
    import rv32i_types::*;

    localparam int TRACE_WORDS = 1024;

    rv32i_word trace [TRACE_WORDS];
    rv32i_word wb_pc_q [$];
    rv32i_reg  wb_rd_q [$];
    rv32i_word wb_data_q [$];
    rv32i_word rd_pc_q [$];
    rv32i_word rd_target_q [$];

    function automatic int outstanding();
        return wb_pc_q.size() + rd_pc_q.size();
    endfunction

    task automatic compare_word(input string name, input rv32i_word got, input rv32i_word exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
            mismatch_o++;
        end
    endtask

    // ########################################
    // expected reports
    // ########################################

    initial begin : load_expected
        int rec;
        mismatch_o   = 0;
        other_errs_o = 0;
        rec          = 0;
        $readmemh("verif/ex_trace.txt", trace);
        while (rec < TRACE_WORDS / 4 && !$isunknown(trace[4*rec]) && trace[4*rec] != '0) begin
            if (trace[4*rec] == 3) begin
                wb_pc_q.push_back(trace[4*rec+1]);
                wb_rd_q.push_back(rv32i_reg'(trace[4*rec+2]));
                wb_data_q.push_back(trace[4*rec+3]);
            end else if (trace[4*rec] == 4) begin
                rd_pc_q.push_back(trace[4*rec+1]);
                rd_target_q.push_back(trace[4*rec+2]);
            end
            rec++;
        end
        pending_o = outstanding();
        if (pending_o == 0) begin
            $display("the trace holds no expected reports, the file is missing or empty");
            other_errs_o++;
        end
    end

    // ########################################
    // in-order comparison
    // ########################################

    task automatic check_writeback();
        if (wb_pc_q.size() == 0) begin
            $display("%0t ns: writeback to x%0d from pc %h was not expected",
                     $time, wb_rd_i, wb_pc_i);
            other_errs_o++;
        end else begin
            compare_word("wb_pc_o", wb_pc_i, wb_pc_q.pop_front());
            compare_word("wb_rd_o", rv32i_word'(wb_rd_i), rv32i_word'(wb_rd_q.pop_front()));
            compare_word("wb_data_o", wb_data_i, wb_data_q.pop_front());
        end
    endtask

    task automatic check_redirect();
        rv32i_word src_pc;
        rv32i_word target;
        if (rd_pc_q.size() == 0) begin
            $display("%0t ns: redirect to %h was not expected", $time, redirect_pc_i);
            other_errs_o++;
        end else begin
            src_pc = rd_pc_q.pop_front();
            target = rd_target_q.pop_front();
            if (redirect_pc_i !== target) begin
                $display("[ERROR] %0t ns redirect_pc_o: got %h, expected %h (from pc %h)",
                         $time, redirect_pc_i, target, src_pc);
                mismatch_o++;
            end
        end
    endtask

    always @(negedge clk) begin // outputs settle well before the falling edge
        if (rst_n_i === 1'b1) begin
            if (wb_valid_i !== 1'b0) check_writeback();
            if (redirect_i !== 1'b0) check_redirect();
        end
        pending_o = outstanding();
    end

endmodule

`default_nettype wire

//--- verif/tb_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_top;
    import rv32i_types::*;

    localparam int TRACE_WORDS = 1024;
    localparam int DRAIN_LIMIT = 50;

    logic      clk;
    logic      rst_n_i;
    logic      instr_valid_i;
    rv32i_word instr_i;
    rv32i_word pc_i;
    logic      wb_valid_o;
    rv32i_reg  wb_rd_o;
    rv32i_word wb_data_o;
    rv32i_word wb_pc_o;
    logic      redirect_o;
    rv32i_word redirect_pc_o;
    int        pending;
    int        mismatches;
    int        other_errs;
    int        trace_errs;
    rv32i_word stim [TRACE_WORDS];

    rv32i_ex_core UUT (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .wb_valid_o    (wb_valid_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o),
        .wb_pc_o       (wb_pc_o),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o)
    );

    tb_checker u_checker (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .wb_valid_i    (wb_valid_o),
        .wb_rd_i       (wb_rd_o),
        .wb_data_i     (wb_data_o),
        .wb_pc_i       (wb_pc_o),
        .redirect_i    (redirect_o),
        .redirect_pc_i (redirect_pc_o),
        .pending_o     (pending),
        .mismatch_o    (mismatches),
        .other_errs_o  (other_errs)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ########################################
    // instruction feeder
    // ########################################

    task automatic feed_trace();
        int rec;
        int issued;
        rec    = 0;
        issued = 0;
        $readmemh("verif/ex_trace.txt", stim);
        while (rec < TRACE_WORDS / 4 && !$isunknown(stim[4*rec]) && stim[4*rec] != '0) begin
            if (stim[4*rec] == 1) begin
                @(posedge clk);
                instr_valid_i <= 1'b1;
                pc_i          <= stim[4*rec+1];
                instr_i       <= stim[4*rec+2];
                issued++;
            end else if (stim[4*rec] == 2) begin
                repeat (stim[4*rec+1]) begin
                    @(posedge clk);
                    instr_valid_i <= 1'b0; // idle cycle, pc and instr keep their value
                end
            end else if (stim[4*rec] > 4) begin
                $display("trace record %0d has an unknown kind %h", rec, stim[4*rec]);
                trace_errs++;
            end
            rec++;
        end
        @(posedge clk);
        instr_valid_i <= 1'b0;
        if (issued == 0) begin
            $display("no instruction was issued from the trace");
            trace_errs++;
        end
    endtask

    initial begin : run
        int cycles;
        rst_n_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        pc_i          = '0;
        trace_errs    = 0;
        repeat (2) @(posedge clk);
        rst_n_i <= 1'b1;

        feed_trace();

        cycles = 0;
        while (pending != 0 && cycles < DRAIN_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (pending == 0) begin
            repeat (4) @(posedge clk); // late duplicates still get counted
        end else begin
            $display("timeout after %0d cycles, %0d expected reports never arrived",
                     DRAIN_LIMIT, pending);
        end

        $display("errors: %0d mismatched, %0d unexpected, %0d missing, %0d trace",
                 mismatches, other_errs, pending, trace_errs);
        if (mismatches == 0 && other_errs == 0 && pending == 0 && trace_errs == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+hdl
hdl/rv32i_types.sv
hdl/stage_if.sv
hdl/regfile.sv
hdl/alu.sv
hdl/id_stage.sv
hdl/ex_stage.sv
hdl/wb_stage.sv
hdl/rv32i_ex_core.sv
verif/tb_checker.sv
verif/tb_top.sv

//--- verif/ex_trace.txt
// columns in hex: kind a b c, kind 1 issue (pc instr), 2 idle (cycles), 3 writeback (pc rd data)
// kind 4 redirect (pc target), kind 0 ends the trace
2 00000003 0 0
1 00000100 12300093 0 // addi x1, x0, 0x123
3 00000100 01 00000123
1 00000104 FFB00113 0 // addi x2, x0, -5
3 00000104 02 FFFFFFFB
1 00000108 800001B7 0 // lui x3, 0x80000
3 00000108 03 80000000
1 0000010C 7FF08213 0 // addi x4, x1, 0x7ff
3 0000010C 04 00000922
1 00000110 402082B3 0 // sub x5, x1, x2
3 00000110 05 00000128
1 00000114 4041D313 0 // srai x6, x3, 4
3 00000114 06 F8000000
1 00000118 0011D3B3 0 // srl x7, x3, x1
3 00000118 07 10000000
1 0000011C 00209433 0 // sll x8, x1, x2
3 0000011C 08 18000000
1 00000120 0F014493 0 // xori x9, x2, 0x0f0
3 00000120 09 FFFFFF0B
1 00000124 0030E533 0 // or x10, x1, x3
3 00000124 0A 80000123
1 00000128 F0017593 0 // andi x11, x2, -256
3 00000128 0B FFFFFF00
2 00000001 0 0
1 0000012C 00112633 0 // slt x12, x2, x1
3 0000012C 0C 00000001
1 00000130 001136B3 0 // sltu x13, x2, x1
3 00000130 0D 00000000
1 00000134 FFC12713 0 // slti x14, x2, -4
3 00000134 0E 00000001
1 00000138 FFF0B793 0 // sltiu x15, x1, -1
3 00000138 0F 00000001
1 0000013C 00411813 0 // slli x16, x2, 4
3 0000013C 10 FFFFFFB0
1 00000140 01C15893 0 // srli x17, x2, 28
3 00000140 11 0000000F
1 00000144 0020C933 0 // xor x18, x1, x2
3 00000144 12 FFFFFED8
1 00000148 002089B3 0 // add x19, x1, x2
3 00000148 13 0000011E
1 0000014C 40115A33 0 // sra x20, x2, x1
3 0000014C 14 FFFFFFFF
1 00000150 0021FAB3 0 // and x21, x3, x2
3 00000150 15 80000000
1 00000154 80006B13 0 // ori x22, x0, -2048
3 00000154 16 FFFFF800
1 00000158 12345B97 0 // auipc x23, 0x12345
3 00000158 17 12345158
2 00000002 0 0
1 0000015C 00508013 0 // addi x0, x1, 5
1 00000160 FFFFFCB7 0 // lui x25, 0xfffff
3 00000160 19 FFFFF000
1 00000164 00209863 0 // bne x1, x2, +16
4 00000164 00000174 0
1 00000174 00000C33 0 // add x24, x0, x0
3 00000174 18 00000000
1 00000178 00208463 0 // beq x1, x2, +8
1 0000017C FE114AE3 0 // blt x2, x1, -12
4 0000017C 00000170 0
1 00000170 0220D063 0 // bge x1, x2, +32
4 00000170 00000190 0
1 00000190 00116463 0 // bltu x2, x1, +8
1 00000194 00117663 0 // bgeu x2, x1, +12
4 00000194 000001A0 0
1 000001A0 04000DEF 0 // jal x27, +64
3 000001A0 1B 000001A4
4 000001A0 000001E0 0
1 000001E0 0DE08E67 0 // jalr x28, 0xde(x1)
3 000001E0 1C 000001E4
4 000001E0 00000200 0
1 00000200 000C0863 0 // beq x24, x0, +16
4 00000200 00000210 0
1 00000210 FFCD8E93 0 // addi x29, x27, -4
3 00000210 1D 000001A0
2 00000002 0 0
1 00000214 01CE8F33 0 // add x30, x29, x28
3 00000214 1E 00000384
0 0 0 0
